// ==== common/mask_params.svh ====
// Mask unit dimensions
// Widths of masks, LFSR chunks and entropy words, plus mask FIFO depth
`ifndef MASK_PARAMS_SVH
`define MASK_PARAMS_SVH

// Mask and cipher data width
`define MASK_W 32

// One Galois LFSR chunk
`define CHUNK_W 8

// Parallel chunks, MASK_W / CHUNK_W
`define NUM_CHUNKS 4

// Entropy word, one chunk per acknowledge
`define ENTROPY_W 8

// Buffered masks between PRNG and splitter
`define FIFO_DEPTH 4

`endif

// ==== common/prng_pkg.sv ====
// PRNG-side types and constants
// LFSR taps, per-chunk reset seeds and the cross-chunk bit permutation
`default_nettype none

`include "mask_params.svh"

package prng_pkg;

  // One LFSR state word
  typedef logic [`CHUNK_W-1:0] chunk_t;

  // Selects the next chunk to reseed
  typedef logic [$clog2(`NUM_CHUNKS)-1:0] chunk_idx_t;

  // Entropy word from the outside
  typedef logic [`ENTROPY_W-1:0] entropy_t;

  // Index into the concatenated chunk states
  typedef logic [$clog2(`MASK_W)-1:0] perm_idx_t;

  // Galois feedback for x^8 + x^6 + x^5 + x^4 + 1
  localparam chunk_t LFSR_TAPS = 8'hB8;

  // Nonzero seeds, index 0 is the lowest chunk
  localparam chunk_t DEFAULT_SEEDS [`NUM_CHUNKS] = '{8'hA5, 8'h3C, 8'h71, 8'hE2};

  ////////////////////////////////////////
  // Output bit b takes input bit MASK_PERM[b]
  // Built as (13 * b + 7) mod 32, a bijection
  ////////////////////////////////////////
  localparam perm_idx_t MASK_PERM [`MASK_W] = '{
    5'd7,  5'd20, 5'd1,  5'd14, 5'd27, 5'd8,  5'd21, 5'd2,
    5'd15, 5'd28, 5'd9,  5'd22, 5'd3,  5'd16, 5'd29, 5'd10,
    5'd23, 5'd4,  5'd17, 5'd30, 5'd11, 5'd24, 5'd5,  5'd18,
    5'd31, 5'd12, 5'd25, 5'd6,  5'd19, 5'd0,  5'd13, 5'd26
  };

endpackage

`default_nettype wire

// ==== common/share_pkg.sv ====
// Datapath-side types
// Cipher data words, masks and FIFO bookkeeping
`default_nettype none

`include "mask_params.svh"

package share_pkg;

  // Cipher data word and its shares
  typedef logic [`MASK_W-1:0] data_t;

  // One Boolean mask
  typedef logic [`MASK_W-1:0] mask_t;

  // Fill count, one bit wider than the pointers to reach FIFO_DEPTH
  typedef logic [$clog2(`FIFO_DEPTH):0] fifo_cnt_t;

  // Read and write pointer, wraps naturally
  typedef logic [$clog2(`FIFO_DEPTH)-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

// ==== hw/prng/mask_lfsr_chunk.sv ====
// Single 8-bit Galois LFSR chunk
// Steps on request, seed load wins over a step
`timescale 1ns/1ps
`default_nettype none

`include "mask_params.svh"

module mask_lfsr_chunk #(
  parameter prng_pkg::chunk_t RESET_SEED = prng_pkg::DEFAULT_SEEDS[0]
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             seed_en_i,
  input  wire prng_pkg::chunk_t seed_i,
  input  wire logic             step_i,
  output      prng_pkg::chunk_t state_o
);

  import prng_pkg::*;

  chunk_t state_q;
  chunk_t state_step;

  // Shift right, fold taps back in when a one drops out
  always_comb begin
    state_step = {1'b0, state_q[`CHUNK_W-1:1]};
    if (state_q[0]) begin
      state_step = state_step ^ LFSR_TAPS;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET_SEED;
    end else if (seed_en_i) begin
      // Reseed overrides any pending step
      state_q <= seed_i;
    end else if (step_i) begin
      state_q <= state_step;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

// ==== hw/prng/mask_prng.sv ====
// Masking PRNG with parallel LFSR chunks
// Chunk-wise reseed, cross-chunk permutation and alternating rotation
`timescale 1ns/1ps
`default_nettype none

`include "mask_params.svh"

module mask_prng (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               update_i,
  output      share_pkg::mask_t   mask_o,
  input  wire logic               reseed_req_i,
  output      logic               reseed_ack_o,
  output      logic               entropy_req_o,
  input  wire logic               entropy_ack_i,
  input  wire prng_pkg::entropy_t entropy_i
);

  import prng_pkg::*;
  import share_pkg::*;

  chunk_idx_t              chunk_idx_q;
  chunk_idx_t              chunk_idx_d;
  logic                    entropy_fire;
  logic [`NUM_CHUNKS-1:0] seed_en;
  chunk_t                  seed_word;
  chunk_t                  chunk_state [`NUM_CHUNKS];
  mask_t                   prng_flat;
  mask_t                   perm_flat;
  logic                    phase_q;

  ////////////////////////////////////////
  // Reseed control
  ////////////////////////////////////////

  // Request entropy for as long as the reseed is pending
  assign entropy_req_o = reseed_req_i;
  assign entropy_fire  = entropy_req_o & entropy_ack_i;

  // Done on the word for the last chunk
  assign reseed_ack_o =
      entropy_fire & (chunk_idx_q == chunk_idx_t'(`NUM_CHUNKS - 1));

  always_comb begin
    chunk_idx_d = chunk_idx_q;
    if (reseed_ack_o) begin
      chunk_idx_d = '0;
    end else if (entropy_fire) begin
      chunk_idx_d = chunk_idx_q + chunk_idx_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_idx_q <= '0;
    end else begin
      chunk_idx_q <= chunk_idx_d;
    end
  end

  // Same entropy to every chunk, only the selected one loads
  assign seed_word = entropy_i;

  ////////////////////////////////////////
  // LFSR chunks
  ////////////////////////////////////////
  for (genvar c = 0; c < `NUM_CHUNKS; c++) begin : gen_chunk
    assign seed_en[c] = entropy_fire & (chunk_idx_q == chunk_idx_t'(c));

    mask_lfsr_chunk #(
      .RESET_SEED (DEFAULT_SEEDS[c])
    ) u_chunk (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .seed_en_i (seed_en[c]),
      .seed_i    (seed_word),
      .step_i    (update_i),
      .state_o   (chunk_state[c])
    );

    assign prng_flat[c*`CHUNK_W +: `CHUNK_W] = chunk_state[c];
  end

  // Scatter bits across chunks to break per-LFSR shift patterns
  for (genvar b = 0; b < `MASK_W; b++) begin : gen_perm
    assign perm_flat[b] = prng_flat[MASK_PERM[b]];
  end

  ////////////////////////////////////////
  // Output rotation
  ////////////////////////////////////////

  // Odd phase: chunk 0 goes to the top, the rest move down
  assign mask_o = phase_q ? {perm_flat[`CHUNK_W-1:0], perm_flat[`MASK_W-1:`CHUNK_W]}
                          : perm_flat;

  // Toggles on every update, also when a reseed swallowed the step
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else if (update_i) begin
      phase_q <= ~phase_q;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mask_fifo.sv ====
// Four-entry mask FIFO
// Pulls one PRNG mask per cycle whenever there is room
`timescale 1ns/1ps
`default_nettype none

`include "mask_params.svh"

module mask_fifo (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire share_pkg::mask_t mask_i,
  output      logic             update_o,
  input  wire logic             pop_i,
  output      share_pkg::mask_t head_mask_o,
  output      logic             empty_o
);

  import share_pkg::*;

  mask_t     mem_q [`FIFO_DEPTH];
  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t cnt_q;
  logic      fill_en_q;
  logic      full;
  logic      push;
  logic      pop;

  assign full    = (cnt_q == fifo_cnt_t'(`FIFO_DEPTH));
  assign empty_o = (cnt_q == '0);

  // Refill starts one cycle after reset release
  assign push     = fill_en_q & ~full;
  assign update_o = push;

  // Pop from an empty buffer is ignored
  assign pop = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_en_q <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      cnt_q     <= '0;
    end else begin
      fill_en_q <= 1'b1;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + fifo_ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + fifo_ptr_t'(1);
      end
      // Push and pop together leave the count alone
      if (push && !pop) begin
        cnt_q <= cnt_q + fifo_cnt_t'(1);
      end else if (pop && !push) begin
        cnt_q <= cnt_q - fifo_cnt_t'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= mask_i;
    end
  end

  assign head_mask_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hw/share_split.sv ====
// Boolean share splitter
// Turns a data strobe into data^mask and mask, or an underflow pulse
`timescale 1ns/1ps
`default_nettype none

module share_split (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             data_valid_i,
  input  wire share_pkg::data_t data_i,
  input  wire share_pkg::mask_t head_mask_i,
  input  wire logic             empty_i,
  output      logic             pop_o,
  output      logic             share_valid_o,
  output      share_pkg::data_t share0_o,
  output      share_pkg::data_t share1_o,
  output      logic             underflow_o
);

  import share_pkg::*;

  logic  share_valid_q;
  logic  underflow_q;
  data_t share0_q;
  data_t share1_q;

  // Take the head mask only when one is there
  assign pop_o = data_valid_i & ~empty_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      share_valid_q <= 1'b0;
      underflow_q   <= 1'b0;
    end else begin
      share_valid_q <= pop_o;
      // No back-pressure, strobe is dropped
      underflow_q   <= data_valid_i & empty_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      share0_q <= data_i ^ head_mask_i;
      share1_q <= head_mask_i;
    end
  end

  assign share_valid_o = share_valid_q;
  assign underflow_o   = underflow_q;
  assign share0_o      = share0_q;
  assign share1_o      = share1_q;

endmodule

`default_nettype wire

// ==== hw/mask_unit_top.sv ====
// Masking-randomness unit top
// PRNG feeds a mask FIFO which feeds the share splitter
`timescale 1ns/1ps
`default_nettype none

module mask_unit_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Cipher data in, shares out
  input  wire logic               data_valid_i,
  input  wire share_pkg::data_t   data_i,
  output      logic               share_valid_o,
  output      share_pkg::data_t   share0_o,
  output      share_pkg::data_t   share1_o,
  output      logic               underflow_o,
  // Reseed handshake
  input  wire logic               reseed_req_i,
  output      logic               reseed_ack_o,
  output      logic               entropy_req_o,
  input  wire logic               entropy_ack_i,
  input  wire prng_pkg::entropy_t entropy_i
);

  import share_pkg::*;

  mask_t prng_mask;
  logic  mask_update;
  mask_t head_mask;
  logic  fifo_empty;
  logic  mask_pop;

  ////////////////////////////////////////
  // Mask source
  ////////////////////////////////////////
  mask_prng u_prng (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .update_i      (mask_update),
    .mask_o        (prng_mask),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  // Buffer between PRNG and consumer
  mask_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mask_i      (prng_mask),
    .update_o    (mask_update),
    .pop_i       (mask_pop),
    .head_mask_o (head_mask),
    .empty_o     (fifo_empty)
  );

  ////////////////////////////////////////
  // Consumer
  ////////////////////////////////////////
  share_split u_split (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_valid_i  (data_valid_i),
    .data_i        (data_i),
    .head_mask_i   (head_mask),
    .empty_i       (fifo_empty),
    .pop_o         (mask_pop),
    .share_valid_o (share_valid_o),
    .share0_o      (share0_o),
    .share1_o      (share1_o),
    .underflow_o   (underflow_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_mask_unit.sv ====
// Testbench for the masking-randomness unit
// Table-driven strobes and reseeds checked against a software PRNG model
`timescale 1ns/1ps
`default_nettype none

`include "mask_params.svh"

module tb_mask_unit;

  import prng_pkg::*;
  import share_pkg::*;

  // Row kinds
  localparam logic [1:0] KIND_IDLE   = 2'd0;
  localparam logic [1:0] KIND_DATA   = 2'd1;
  localparam logic [1:0] KIND_BURST  = 2'd2;
  localparam logic [1:0] KIND_RESEED = 2'd3;

  localparam int TABLE_LEN      = 25;
  localparam int TIMEOUT_CYCLES = 4 * TABLE_LEN + 200;

  logic     clk_i;
  logic     rst_ni;
  logic     data_valid_i;
  data_t    data_i;
  logic     share_valid_o;
  data_t    share0_o;
  data_t    share1_o;
  logic     underflow_o;
  logic     reseed_req_i;
  logic     reseed_ack_o;
  logic     entropy_req_o;
  logic     entropy_ack_i;
  entropy_t entropy_i;

  // Idle rows keep their cycle count in the entropy column
  logic [1:0] row_kind [TABLE_LEN];
  data_t      row_data [TABLE_LEN];
  entropy_t   row_entropy [TABLE_LEN];
  int         row_cnt;

  // Software PRNG model and its queue of generated masks
  chunk_t model_chunk [`NUM_CHUNKS];
  logic   model_phase;
  mask_t  model_q [$];

  // Result expected one cycle after the last strobe
  logic  pend_share;
  logic  pend_underflow;
  data_t pend_data;

  int          error_count = 0;
  int          cycle_cnt = 0;
  int          reseed_idx;
  logic [31:0] lcg_state;

  mask_unit_top DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_valid_i  (data_valid_i),
    .data_i        (data_i),
    .share_valid_o (share_valid_o),
    .share0_o      (share0_o),
    .share1_o      (share1_o),
    .underflow_o   (underflow_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_ack_i (entropy_ack_i),
    .entropy_i     (entropy_i)
  );

  always #10 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Galois step folds the taps in when a one is shifted out
  function automatic chunk_t lfsr_step(input chunk_t s);
    chunk_t n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ LFSR_TAPS;
    end
    return n;
  endfunction

  function automatic mask_t model_mask_value();
    mask_t flat;
    mask_t perm;
    int    i;
    for (i = 0; i < `NUM_CHUNKS; i++) begin
      flat[i*`CHUNK_W +: `CHUNK_W] = model_chunk[i];
    end
    for (i = 0; i < `MASK_W; i++) begin
      perm[i] = flat[MASK_PERM[i]];
    end
    // Odd phase puts chunk 0 on top
    if (model_phase) begin
      perm = {perm[`CHUNK_W-1:0], perm[`MASK_W-1:`CHUNK_W]};
    end
    return perm;
  endfunction

  task automatic gen_mask();
    int i;
    model_q.push_back(model_mask_value());
    for (i = 0; i < `NUM_CHUNKS; i++) begin
      model_chunk[i] = lfsr_step(model_chunk[i]);
    end
    model_phase = ~model_phase;
  endtask

  task automatic pop_expected(output mask_t m);
    if (model_q.size() == 0) begin
      gen_mask();
    end
    m = model_q.pop_front();
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_mask(input string what, input mask_t got, input mask_t exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "mask mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Checks last cycle's result, then drives the next inputs
  task automatic step_cycle(input logic valid, input data_t data, input logic req,
                            input logic ack, input entropy_t ent, input logic exp_ack);
    mask_t exp_mask;
    @(posedge clk_i);
    #2;
    if (pend_share) begin
      pop_expected(exp_mask);
      check_flag("share_valid_o", share_valid_o, 1'b1);
      check_flag("underflow_o", underflow_o, 1'b0);
      check_data("share0_o ^ share1_o", share0_o ^ share1_o, pend_data);
      check_mask("share1_o", share1_o, exp_mask);
    end else begin
      check_flag("share_valid_o", share_valid_o, 1'b0);
      check_flag("underflow_o", underflow_o, pend_underflow);
    end
    data_valid_i   = valid;
    data_i         = data;
    reseed_req_i   = req;
    entropy_ack_i  = ack;
    entropy_i      = ent;
    pend_share     = valid;
    pend_underflow = 1'b0;
    pend_data      = data;
    // Combinational handshake outputs are sampled mid-cycle
    #6;
    check_flag("entropy_req_o", entropy_req_o, reseed_req_i);
    check_flag("reseed_ack_o", reseed_ack_o, exp_ack);
  endtask

  task automatic idle_cycle();
    step_cycle(1'b0, '0, 1'b0, 1'b0, '0, 1'b0);
  endtask

  task automatic add_row(input logic [1:0] kind, input entropy_t ent);
    lcg_state             = lcg_next(lcg_state);
    row_kind[row_cnt]    = kind;
    row_data[row_cnt]    = lcg_state;
    row_entropy[row_cnt] = ent;
    row_cnt++;
  endtask

  task automatic build_table();
    row_cnt = 0;
    add_row(KIND_IDLE, 8'd10);
    repeat (4) add_row(KIND_DATA, 8'h00);
    add_row(KIND_IDLE, 8'd6);
    // Back-to-back strobes on a full FIFO
    repeat (5) add_row(KIND_BURST, 8'h00);
    add_row(KIND_IDLE, 8'd20);
    add_row(KIND_RESEED, 8'hA1);
    add_row(KIND_RESEED, 8'h5E);
    add_row(KIND_RESEED, 8'hC3);
    add_row(KIND_RESEED, 8'h37);
    // Four buffered masks, then four from the new seeds
    repeat (8) add_row(KIND_DATA, 8'h00);
    add_row(KIND_IDLE, 8'd4);
  endtask

  task automatic apply_row(input int r);
    case (row_kind[r])
      KIND_IDLE: begin
        repeat (int'(row_entropy[r])) idle_cycle();
      end
      KIND_DATA: begin
        step_cycle(1'b1, row_data[r], 1'b0, 1'b0, '0, 1'b0);
        idle_cycle();
      end
      KIND_BURST: begin
        step_cycle(1'b1, row_data[r], 1'b0, 1'b0, '0, 1'b0);
      end
      default: begin
        // FIFO is full, so the PRNG already holds four masks ahead
        if (reseed_idx == 0) begin
          while (model_q.size() < `FIFO_DEPTH) begin
            gen_mask();
          end
        end
        model_chunk[reseed_idx] = row_entropy[r];
        step_cycle(1'b0, '0, 1'b1, 1'b1, row_entropy[r], reseed_idx == `NUM_CHUNKS - 1);
        reseed_idx = (reseed_idx + 1) % `NUM_CHUNKS;
      end
    endcase
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    data_valid_i   = 1'b0;
    data_i         = '0;
    reseed_req_i   = 1'b0;
    entropy_ack_i  = 1'b0;
    entropy_i      = '0;
    pend_share     = 1'b0;
    pend_underflow = 1'b0;
    pend_data      = '0;
    reseed_idx     = 0;
    model_phase    = 1'b0;
    for (int i = 0; i < `NUM_CHUNKS; i++) begin
      model_chunk[i] = DEFAULT_SEEDS[i];
    end
    lcg_state = 32'h128b_3391;
    build_table();

    repeat (16) @(posedge clk_i);
    #2;
    // Strobe on release finds the FIFO still empty
    rst_ni         = 1'b1;
    lcg_state      = lcg_next(lcg_state);
    data_valid_i   = 1'b1;
    data_i         = lcg_state;
    pend_underflow = 1'b1;

    for (int r = 0; r < TABLE_LEN; r++) begin
      apply_row(r);
    end

    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/prng_pkg.sv
common/share_pkg.sv
hw/prng/mask_lfsr_chunk.sv
hw/prng/mask_prng.sv
hw/mask_fifo.sv
hw/share_split.sv
hw/mask_unit_top.sv
tests/tb_mask_unit.sv

// ==== Bender.yml ====
package:
  name: mask_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/prng_pkg.sv
      - common/share_pkg.sv
      - hw/prng/mask_lfsr_chunk.sv
      - hw/prng/mask_prng.sv
      - hw/mask_fifo.sv
      - hw/share_split.sv
      - hw/mask_unit_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_mask_unit.sv
